//--- rtl/pe_pkg.sv
`default_nettype none

package pe_pkg;

  // ======================================================================
  // widths
  // ======================================================================
  typedef logic [31:0] word_t;        // bus and ram word
  typedef logic [15:0] flit_t;        // one link flit
  typedef logic [7:0]  ram_addr_t;    // ram word index, host addr bits 9..2
  typedef logic [15:0] tile_addr_t;   // x in high byte, y in low byte
  typedef logic [6:0]  dma_len_t;     // transfer length in words
  typedef logic [2:0]  credit_cnt_t;  // link credits on hand

  // serializer walks header, length, then two halves per word
  typedef enum logic [2:0] {
    SER_IDLE,
    SER_HEADER,
    SER_LENGTH,
    SER_PAYLOAD_HIGH,
    SER_PAYLOAD_LOW
  } ser_state_t;

  // ======================================================================
  // address map
  // ======================================================================
  localparam word_t PERIPH_BASE    = 32'he100_0000; // tile id lives here
  localparam word_t REG_DMA_SRC    = 32'd4;         // source word index
  localparam word_t REG_DMA_LEN    = 32'd8;         // words to send
  localparam word_t REG_DMA_DST    = 32'd12;        // dest tile, write starts
  localparam word_t REG_DMA_STATUS = 32'd16;        // bit0 busy, bit1 irq

  // ======================================================================
  // sizes and link limits
  // ======================================================================
  localparam int RAM_DEPTH     = 256;
  localparam int MAX_DMA_WORDS = 64;

  // credits held after reset, one per slot in the router input buffer
  localparam credit_cnt_t LINK_CREDITS = 3'd4;

endpackage : pe_pkg

`default_nettype wire

//--- rtl/pe_apb_decode.sv
`default_nettype none

module pe_apb_decode #(
  parameter pe_pkg::tile_addr_t TILE_ADDRESS = '0
) (
  input  wire logic               clock,
  input  wire logic               reset,
  input  wire logic               psel_i,
  input  wire logic               penable_i,
  input  wire logic               pwrite_i,
  input  wire pe_pkg::word_t      paddr_i,
  input  wire pe_pkg::word_t      pwdata_i,
  output pe_pkg::word_t           prdata_o,
  output logic                    pready_o,
  output logic                    pslverr_o,
  output logic                    ram_we_o,
  output pe_pkg::ram_addr_t       ram_addr_o,
  output pe_pkg::word_t           ram_wdata_o,
  input  wire pe_pkg::word_t      ram_rdata_i,
  output logic                    dma_start_o,
  output pe_pkg::ram_addr_t       dma_src_o,
  output pe_pkg::dma_len_t        dma_len_o,
  output pe_pkg::tile_addr_t      dma_dst_o,
  input  wire logic               sent_last_i,
  output logic                    irq_o
);
  import pe_pkg::*;

  logic       wait_q;   // first access cycle done
  logic       busy_q;
  logic       irq_q;
  logic       start_q;
  ram_addr_t  src_q;
  dma_len_t   len_q;
  tile_addr_t dst_q;
  word_t      offset;   // byte offset into peripheral range
  logic       is_ram;
  logic       addr_err;
  logic       busy_err;
  logic       len_err;
  logic       err;
  logic       done;     // completing access cycle
  logic       wr_ok;

  // ======================================================================
  // decode and error response
  // ======================================================================
  assign is_ram = paddr_i < PERIPH_BASE;
  assign offset = paddr_i - PERIPH_BASE;

  assign addr_err = (paddr_i[1:0] != 2'b00) ||
                    (is_ram ? (paddr_i >= word_t'(RAM_DEPTH * 4))
                            : (offset > REG_DMA_STATUS));
  // dma setup frozen while a transfer runs
  assign busy_err = pwrite_i && !is_ram && busy_q &&
                    (offset == REG_DMA_SRC || offset == REG_DMA_LEN ||
                     offset == REG_DMA_DST);
  assign len_err  = pwrite_i && !is_ram && (offset == REG_DMA_DST) &&
                    (len_q == '0 || len_q > dma_len_t'(MAX_DMA_WORDS));
  assign err      = addr_err || busy_err || len_err;

  assign done      = psel_i && penable_i && wait_q;
  assign wr_ok     = done && pwrite_i && !err;  // bad writes change nothing
  assign pready_o  = done;
  assign pslverr_o = done && err;

  // ram side, byte order swapped both ways
  assign ram_we_o    = wr_ok && is_ram;
  assign ram_addr_o  = paddr_i[9:2];
  assign ram_wdata_o = {<<8{pwdata_i}};

  always_comb begin
    prdata_o = '0;
    if (is_ram) begin
      prdata_o = {<<8{ram_rdata_i}}; // ram data arrives in 2nd access cycle
    end else begin
      unique case (offset)
        32'd0:          prdata_o = {16'b0, TILE_ADDRESS};
        REG_DMA_SRC:    prdata_o = {24'b0, src_q};
        REG_DMA_LEN:    prdata_o = {25'b0, len_q};
        REG_DMA_DST:    prdata_o = {16'b0, dst_q};
        REG_DMA_STATUS: prdata_o = {30'b0, irq_q, busy_q};
        default:        prdata_o = '0;
      endcase
    end
  end

  // ======================================================================
  // wait state, dma registers, busy and irq
  // ======================================================================
  always_ff @(posedge clock) begin
    if (!reset) begin
      wait_q  <= 1'b0;
      busy_q  <= 1'b0;
      irq_q   <= 1'b0;
      start_q <= 1'b0;
      src_q   <= '0;
      len_q   <= '0;
      dst_q   <= '0;
    end else begin
      wait_q  <= psel_i && penable_i && !wait_q; // one wait state per access
      start_q <= 1'b0;
      if (wr_ok && !is_ram) begin
        unique case (offset)
          REG_DMA_SRC: src_q <= pwdata_i[7:0];
          REG_DMA_LEN: len_q <= pwdata_i[6:0];
          REG_DMA_DST: begin
            dst_q   <= pwdata_i[15:0];
            start_q <= 1'b1;
            busy_q  <= 1'b1;
          end
          REG_DMA_STATUS: if (pwdata_i[1]) irq_q <= 1'b0; // write 1 to clear
          default: ;                                     // id is read only
        endcase
      end
      // end of packet beats a clear in the same cycle
      if (sent_last_i) begin
        busy_q <= 1'b0;
        irq_q  <= 1'b1;
      end
    end
  end

  assign dma_start_o = start_q;
  assign dma_src_o   = src_q;
  assign dma_len_o   = len_q;
  assign dma_dst_o   = dst_q;
  assign irq_o       = irq_q;

endmodule : pe_apb_decode

`default_nettype wire

//--- rtl/pe_dual_port_ram.sv
`default_nettype none

module pe_dual_port_ram (
  input  wire logic               clock,
  // port a, host read/write
  input  wire logic               a_we_i,
  input  wire pe_pkg::ram_addr_t  a_addr_i,
  input  wire pe_pkg::word_t      a_wdata_i,
  output pe_pkg::word_t           a_rdata_o,
  // port b, dma read only
  input  wire pe_pkg::ram_addr_t  b_addr_i,
  output pe_pkg::word_t           b_rdata_o
);
  import pe_pkg::*;

  word_t mem [RAM_DEPTH];  // contents undefined after power up

  // ======================================================================
  // port a
  // ======================================================================
  always_ff @(posedge clock) begin
    if (a_we_i) begin
      mem[a_addr_i] <= a_wdata_i;
    end
    a_rdata_o <= mem[a_addr_i]; // old data on a write, one cycle latency
  end

  // ======================================================================
  // port b
  // ======================================================================
  always_ff @(posedge clock) begin
    b_rdata_o <= mem[b_addr_i]; // read every cycle, fetch picks its cycle
  end

endmodule : pe_dual_port_ram

`default_nettype wire

//--- rtl/pe_dma_fetch.sv
`default_nettype none

module pe_dma_fetch (
  input  wire logic                clock,
  input  wire logic                reset,
  input  wire logic                start_i,
  input  wire pe_pkg::ram_addr_t   src_i,
  input  wire pe_pkg::dma_len_t    len_i,
  input  wire pe_pkg::tile_addr_t  dst_i,
  output pe_pkg::ram_addr_t        rd_addr_o,
  input  wire pe_pkg::word_t       rd_data_i,
  output logic                     word_valid_o,
  input  wire logic                word_ready_i,
  output pe_pkg::word_t            word_o,
  output logic                     sop_o,
  output pe_pkg::tile_addr_t       dest_o,
  output pe_pkg::dma_len_t         len_o
);
  import pe_pkg::*;

  ram_addr_t  addr_q;    // next word to read
  dma_len_t   remain_q;  // reads still to issue
  logic       pend_q;    // read in flight
  logic       valid_q;
  logic       first_q;   // next captured word opens the packet
  logic       sop_q;
  word_t      word_q;
  tile_addr_t dest_q;
  dma_len_t   len_q;
  logic       issue;

  // one read at a time, only when the output slot frees up
  assign issue = (remain_q != '0) && !pend_q &&
                 (!valid_q || word_ready_i);

  always_ff @(posedge clock) begin
    if (!reset) begin
      remain_q <= '0;
      pend_q   <= 1'b0;
      valid_q  <= 1'b0;
      first_q  <= 1'b0;
      sop_q    <= 1'b0;
    end else begin
      pend_q <= issue;
      if (start_i) begin
        remain_q <= len_i;
        first_q  <= 1'b1;
      end else if (issue) begin
        remain_q <= remain_q - 1'b1;
      end
      if (pend_q) begin
        valid_q <= 1'b1;     // slot is empty here, see issue
        sop_q   <= first_q;
        first_q <= 1'b0;
      end else if (valid_q && word_ready_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  // payload and address, no reset needed
  always_ff @(posedge clock) begin
    if (start_i) begin
      addr_q <= src_i;
      dest_q <= dst_i;
      len_q  <= len_i;
    end else if (issue) begin
      addr_q <= addr_q + 1'b1;
    end
    if (pend_q) word_q <= rd_data_i;  // ram data for last cycle's addr
  end

  assign rd_addr_o    = addr_q;
  assign word_valid_o = valid_q;
  assign word_o       = word_q;
  assign sop_o        = sop_q;
  assign dest_o       = dest_q;
  assign len_o        = len_q;

endmodule : pe_dma_fetch

`default_nettype wire

//--- rtl/pe_flit_serializer.sv
`default_nettype none

module pe_flit_serializer (
  input  wire logic                clock,
  input  wire logic                reset,
  input  wire logic                word_valid_i,
  output logic                     word_ready_o,
  input  wire pe_pkg::word_t       word_i,
  input  wire logic                sop_i,
  input  wire pe_pkg::tile_addr_t  dest_i,
  input  wire pe_pkg::dma_len_t    len_i,
  output logic                     flit_valid_o,
  input  wire logic                flit_ready_i,
  output pe_pkg::flit_t            flit_o,
  output logic                     flit_last_o
);
  import pe_pkg::*;

  ser_state_t state_q;
  dma_len_t   cnt_q;      // words left after the current one
  word_t      word_q;
  tile_addr_t dest_q;
  dma_len_t   len_q;
  logic       take_word;
  logic       flit_fire;

  // take a word when idle or as the low half leaves, no bubble
  assign word_ready_o = (state_q == SER_IDLE) ||
                        (state_q == SER_PAYLOAD_LOW && flit_ready_i);
  assign take_word    = word_valid_i && word_ready_o;
  assign flit_valid_o = (state_q != SER_IDLE);
  assign flit_fire    = flit_valid_o && flit_ready_i;
  assign flit_last_o  = (state_q == SER_PAYLOAD_LOW) && (cnt_q == '0);

  always_comb begin
    unique case (state_q)
      SER_HEADER:       flit_o = dest_q;
      SER_LENGTH:       flit_o = {9'b0, len_q};
      SER_PAYLOAD_HIGH: flit_o = word_q[31:16];
      SER_PAYLOAD_LOW:  flit_o = word_q[15:0];
      default:          flit_o = '0;
    endcase
  end

  // ======================================================================
  // state machine
  // ======================================================================
  always_ff @(posedge clock) begin
    if (!reset) begin
      state_q <= SER_IDLE;
      cnt_q   <= '0;
    end else begin
      if (take_word) begin
        cnt_q <= (sop_i ? len_i : cnt_q) - 1'b1; // sop reloads the count
      end
      unique case (state_q)
        SER_IDLE: begin
          if (take_word) state_q <= sop_i ? SER_HEADER : SER_PAYLOAD_HIGH;
        end
        SER_HEADER:       if (flit_fire) state_q <= SER_LENGTH;
        SER_LENGTH:       if (flit_fire) state_q <= SER_PAYLOAD_HIGH;
        SER_PAYLOAD_HIGH: if (flit_fire) state_q <= SER_PAYLOAD_LOW;
        SER_PAYLOAD_LOW: begin
          if (flit_fire) begin
            if (take_word) state_q <= sop_i ? SER_HEADER : SER_PAYLOAD_HIGH;
            else           state_q <= SER_IDLE;
          end
        end
        default: state_q <= SER_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (take_word) begin
      word_q <= word_i;
      if (sop_i) begin  // header fields only valid with sop
        dest_q <= dest_i;
        len_q  <= len_i;
      end
    end
  end

endmodule : pe_flit_serializer

`default_nettype wire

//--- rtl/pe_credit_tx.sv
`default_nettype none

module pe_credit_tx (
  input  wire logic           clock,
  input  wire logic           reset,
  input  wire logic           flit_valid_i,
  output logic                flit_ready_o,
  input  wire pe_pkg::flit_t  flit_i,
  input  wire logic           flit_last_i,
  output logic                tx_o,
  output pe_pkg::flit_t       data_o,
  input  wire logic           credit_i,
  output logic                sent_last_o
);
  import pe_pkg::*;

  credit_cnt_t credit_q;
  logic        tx_q;
  logic        last_q;
  flit_t       data_q;
  logic        send;

  assign flit_ready_o = (credit_q != '0);  // stall with no room downstream
  assign send         = flit_valid_i && flit_ready_o;

  always_ff @(posedge clock) begin
    if (!reset) begin
      credit_q <= LINK_CREDITS;
      tx_q     <= 1'b0;
      last_q   <= 1'b0;
    end else begin
      tx_q   <= send;                  // flit on the link next cycle
      last_q <= send && flit_last_i;
      unique case ({send, credit_i})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: ;                     // both or neither, count holds
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (send) data_q <= flit_i;
  end

  assign tx_o        = tx_q;
  assign data_o      = data_q;
  assign sent_last_o = last_q;

endmodule : pe_credit_tx

`default_nettype wire

//--- rtl/pe_tile.sv
`default_nettype none

module pe_tile #(
  parameter pe_pkg::tile_addr_t TILE_ADDRESS = '0
) (
  input  wire logic           clock,
  input  wire logic           reset,
  input  wire logic           psel_i,
  input  wire logic           penable_i,
  input  wire logic           pwrite_i,
  input  wire pe_pkg::word_t  paddr_i,
  input  wire pe_pkg::word_t  pwdata_i,
  output pe_pkg::word_t       prdata_o,
  output logic                pready_o,
  output logic                pslverr_o,
  output logic                tx_o,
  output pe_pkg::flit_t       data_o,
  input  wire logic           credit_i,
  output logic                irq_o
);
  import pe_pkg::*;

  // ======================================================================
  // internal nets
  // ======================================================================
  logic       ram_we;
  ram_addr_t  ram_addr;
  word_t      ram_wdata;
  word_t      ram_rdata;
  logic       dma_start;
  ram_addr_t  dma_src;
  dma_len_t   dma_len;
  tile_addr_t dma_dst;
  ram_addr_t  fetch_addr;
  word_t      fetch_data;
  logic       word_valid;
  logic       word_ready;
  word_t      word;
  logic       sop;
  tile_addr_t word_dest;
  dma_len_t   word_len;
  logic       flit_valid;
  logic       flit_ready;
  flit_t      flit;
  logic       flit_last;
  logic       sent_last;

  pe_apb_decode #(
    .TILE_ADDRESS(TILE_ADDRESS)
  ) u_decode (
    .clock(clock), .reset(reset),
    .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
    .paddr_i(paddr_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
    .pready_o(pready_o), .pslverr_o(pslverr_o),
    .ram_we_o(ram_we), .ram_addr_o(ram_addr),
    .ram_wdata_o(ram_wdata), .ram_rdata_i(ram_rdata),
    .dma_start_o(dma_start), .dma_src_o(dma_src),
    .dma_len_o(dma_len), .dma_dst_o(dma_dst),
    .sent_last_i(sent_last), .irq_o(irq_o)
  );

  pe_dual_port_ram u_ram (
    .clock(clock),
    .a_we_i(ram_we), .a_addr_i(ram_addr),
    .a_wdata_i(ram_wdata), .a_rdata_o(ram_rdata),
    .b_addr_i(fetch_addr), .b_rdata_o(fetch_data)
  );

  // dma pipeline, fetch -> serializer -> link
  pe_dma_fetch u_fetch (
    .clock(clock), .reset(reset),
    .start_i(dma_start), .src_i(dma_src), .len_i(dma_len), .dst_i(dma_dst),
    .rd_addr_o(fetch_addr), .rd_data_i(fetch_data),
    .word_valid_o(word_valid), .word_ready_i(word_ready), .word_o(word),
    .sop_o(sop), .dest_o(word_dest), .len_o(word_len)
  );

  pe_flit_serializer u_ser (
    .clock(clock), .reset(reset),
    .word_valid_i(word_valid), .word_ready_o(word_ready), .word_i(word),
    .sop_i(sop), .dest_i(word_dest), .len_i(word_len),
    .flit_valid_o(flit_valid), .flit_ready_i(flit_ready),
    .flit_o(flit), .flit_last_o(flit_last)
  );

  pe_credit_tx u_tx (
    .clock(clock), .reset(reset),
    .flit_valid_i(flit_valid), .flit_ready_o(flit_ready),
    .flit_i(flit), .flit_last_i(flit_last),
    .tx_o(tx_o), .data_o(data_o), .credit_i(credit_i),
    .sent_last_o(sent_last)
  );

endmodule : pe_tile

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
  output logic clock_o,
  output logic reset_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD  = 20;  // 40 ns clock
  localparam int RESET_CYCLES = 16;

  initial begin
    clock_o = 1'b0;
    forever #HALF_PERIOD clock_o = ~clock_o;
  end

  // active low, released on a rising edge
  initial begin
    reset_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock_o);
    reset_o <= 1'b1;
  end

endmodule : tb_clock_gen

`default_nettype wire

//--- testbench/tb_pe_tile.sv
`default_nettype none

module tb_pe_tile;
  timeunit 1ns;
  timeprecision 100ps;
  import pe_pkg::*;

  // ======================================================================
  // setup, run length and watchdog
  // ======================================================================
  localparam tile_addr_t TILE_ADDRESS  = 16'h0203;
  localparam logic [31:0] LFSR_TAPS    = 32'ha300_0000;
  localparam int          CREDIT_DELAY = 3;    // sink holds each credit this long
  localparam int          APB_TRANSFERS = 100; // 1+17+12+11+36+23 over the six tests
  localparam int          LINK_FLITS    = 70;  // 12+14+22+22
  localparam int CYCLE_LIMIT = (20 * APB_TRANSFERS + 10 * LINK_FLITS) * 3 / 2;

  logic       clock;
  logic       reset;
  logic       psel;
  logic       penable;
  logic       pwrite;
  word_t      paddr;
  word_t      pwdata;
  word_t      prdata;
  logic       pready;
  logic       pslverr;
  logic       tx_o;
  flit_t      data_o;
  logic       credit_i = 1'b0;
  logic       irq_o;

  logic [31:0]             lfsr_q = 32'hc86a;
  logic                    sink_paused = 1'b0;
  logic [CREDIT_DELAY-1:0] credit_pipe = '0;
  int                      owed = 0;          // credits waiting to go back
  int                      cycle_count = 0;
  int                      error_count = 0;
  int                      check_total = 0;
  int                      tests_run = 0;
  int                      tests_failed = 0;
  flit_t                   rx_flits[$];       // everything seen on the link
  flit_t                   exp_flits[$];
  word_t                   mem_model [RAM_DEPTH]; // bus view of ram

  tb_clock_gen clock_gen0 (.clock_o(clock), .reset_o(reset));

  pe_tile #(.TILE_ADDRESS(TILE_ADDRESS)) dut0 (
    .clock(clock), .reset(reset),
    .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
    .paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata),
    .pready_o(pready), .pslverr_o(pslverr),
    .tx_o(tx_o), .data_o(data_o), .credit_i(credit_i), .irq_o(irq_o)
  );

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the DUT never completed a handshake", cycle_count);
      $display("TEST FAILED");
      $finish;
    end
  end

  // link sink, records flits and hands credits back
  always @(posedge clock) begin
    if (tx_o === 1'b1) rx_flits.push_back(data_o);
    owed = owed + int'(credit_pipe[CREDIT_DELAY-1]);
    credit_pipe <= {credit_pipe[CREDIT_DELAY-2:0], tx_o === 1'b1};
    if (!sink_paused && owed > 0) begin
      credit_i <= 1'b1;   // one credit per cycle at most
      owed = owed - 1;
    end else begin
      credit_i <= 1'b0;
    end
  end

  // ======================================================================
  // helpers
  // ======================================================================
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);  // one step per bit
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic word_t swap_bytes(input word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  function automatic word_t ram_byte_addr(input ram_addr_t idx);
    return {22'b0, idx, 2'b00};
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    check_total++;
    if (got !== exp) begin
      $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_flit(input string name, input flit_t got, input flit_t exp);
    check_total++;
    if (got !== exp) begin
      $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_total++;
    if (got !== exp) begin
      $display("Error at %0d ns: %s is %b, expected %b", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    check_total++;
    if (got != exp) begin
      $display("Error at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic apb_write(input word_t addr, input word_t data, output logic err);
    @(posedge clock);
    psel    <= 1'b1;       // setup
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clock);
    penable <= 1'b1;
    @(posedge clock);
    check_bit("pready", pready, 1'b0);  // first access cycle is the wait state
    while (!pready) @(posedge clock);  // wait state
    err = pslverr;
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(input word_t addr, output word_t data, output logic err);
    @(posedge clock);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clock);
    penable <= 1'b1;
    @(posedge clock);
    check_bit("pready", pready, 1'b0);
    while (!pready) @(posedge clock);
    data = prdata;
    err  = pslverr;
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic load_words(input ram_addr_t base, input int n);
    logic      err;
    word_t     data;
    ram_addr_t idx;
    for (int i = 0; i < n; i++) begin
      idx  = ram_addr_t'(int'(base) + i);
      data = random_bits(32);
      apb_write(ram_byte_addr(idx), data, err);
      check_bit("pslverr", err, 1'b0);
      mem_model[idx] = data;
    end
  endtask

  task automatic start_dma(input ram_addr_t src, input dma_len_t len, input tile_addr_t dst);
    logic err;
    apb_write(PERIPH_BASE + REG_DMA_SRC, word_t'(src), err);
    check_bit("pslverr", err, 1'b0);
    apb_write(PERIPH_BASE + REG_DMA_LEN, word_t'(len), err);
    check_bit("pslverr", err, 1'b0);
    apb_write(PERIPH_BASE + REG_DMA_DST, word_t'(dst), err);  // starts it
    check_bit("pslverr", err, 1'b0);
  endtask

  // header, length, then high and low half of each stored word
  task automatic expect_packet(input ram_addr_t src, input dma_len_t len, input tile_addr_t dst);
    word_t stored;
    exp_flits.push_back(dst);
    exp_flits.push_back({9'b0, len});
    for (int i = 0; i < int'(len); i++) begin
      stored = swap_bytes(mem_model[ram_addr_t'(int'(src) + i)]);
      exp_flits.push_back(stored[31:16]);
      exp_flits.push_back(stored[15:0]);
    end
  endtask

  task automatic check_packet();
    while (rx_flits.size() < exp_flits.size()) @(posedge clock);
    repeat (8) @(posedge clock);  // catch stray flits
    check_count("flit count", rx_flits.size(), exp_flits.size());
    for (int i = 0; i < exp_flits.size() && i < rx_flits.size(); i++) begin
      check_flit($sformatf("data_o flit %0d", i), rx_flits[i], exp_flits[i]);
    end
    rx_flits.delete();
    exp_flits.delete();
  endtask

  task automatic wait_irq();
    while (!irq_o) @(posedge clock);
  endtask

  task automatic clear_irq();
    logic  err;
    word_t rd;
    apb_write(PERIPH_BASE + REG_DMA_STATUS, 32'h2, err);
    check_bit("pslverr", err, 1'b0);
    apb_read(PERIPH_BASE + REG_DMA_STATUS, rd, err);
    check_word("dma status", rd, 32'h0);
    check_bit("irq_o", irq_o, 1'b0);
  endtask

  task automatic report_test(input string name, input int errors_at_start);
    tests_run++;
    if (error_count == errors_at_start) begin
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: failed, %0d errors", name, error_count - errors_at_start);
    end
  endtask

  // ======================================================================
  // tests
  // ======================================================================
  task automatic test_reset();
    int    errs;
    logic  err;
    word_t rd;
    errs = error_count;
    check_bit("tx_o", tx_o, 1'b0);
    check_bit("irq_o", irq_o, 1'b0);
    check_bit("pready", pready, 1'b0);
    check_bit("pslverr", pslverr, 1'b0);
    apb_read(PERIPH_BASE + REG_DMA_STATUS, rd, err);
    check_bit("pslverr", err, 1'b0);
    check_word("dma status", rd, 32'h0);
    report_test("reset state", errs);
  endtask

  task automatic test_ram_readback();
    int        errs;
    logic      err;
    word_t     rd;
    ram_addr_t idx[8];
    word_t     data;
    errs = error_count;
    for (int i = 0; i < 8; i++) begin
      idx[i] = ram_addr_t'(random_bits(8));
      data   = random_bits(32);
      apb_write(ram_byte_addr(idx[i]), data, err);
      check_bit("pslverr", err, 1'b0);
      mem_model[idx[i]] = data;   // later writes win on repeats
    end
    for (int i = 0; i < 8; i++) begin
      apb_read(ram_byte_addr(idx[i]), rd, err);
      check_bit("pslverr", err, 1'b0);
      check_word($sformatf("ram word %0d", idx[i]), rd, mem_model[idx[i]]);
    end
    apb_read(PERIPH_BASE, rd, err);
    check_bit("pslverr", err, 1'b0);
    check_word("tile address", rd, {16'b0, TILE_ADDRESS});
    report_test("ram readback", errs);
  endtask

  task automatic test_dma_packet();
    int    errs;
    logic  err;
    word_t rd;
    errs = error_count;
    rx_flits.delete();
    load_words(8'd16, 5);
    start_dma(8'd16, 7'd5, 16'h0105);
    expect_packet(8'd16, 7'd5, 16'h0105);
    apb_read(PERIPH_BASE + REG_DMA_STATUS, rd, err);
    check_word("dma status", rd, 32'h1);   // busy only
    wait_irq();
    check_packet();
    apb_read(PERIPH_BASE + REG_DMA_STATUS, rd, err);
    check_word("dma status", rd, 32'h2);   // done, irq pending
    clear_irq();
    report_test("dma packet", errs);
  endtask

  task automatic test_backpressure();
    int errs;
    errs = error_count;
    rx_flits.delete();
    sink_paused <= 1'b1;
    load_words(8'd40, 6);
    start_dma(8'd40, 7'd6, 16'h0300);
    expect_packet(8'd40, 7'd6, 16'h0300);
    repeat (40) @(posedge clock);     // observation window, link starved
    check_count("flits while paused", rx_flits.size(), int'(LINK_CREDITS));
    check_bit("irq_o", irq_o, 1'b0);
    sink_paused <= 1'b0;
    wait_irq();
    check_packet();
    clear_irq();
    report_test("back-pressure", errs);
  endtask

  task automatic test_errors();
    int    errs;
    logic  err;
    word_t rd;
    errs = error_count;
    load_words(8'd0, 1);
    // unaligned
    apb_write(32'h0000_0042, ~mem_model[16], err);
    check_bit("pslverr unaligned write", err, 1'b1);
    apb_read(32'h0000_0042, rd, err);
    check_bit("pslverr unaligned read", err, 1'b1);
    apb_read(ram_byte_addr(8'd16), rd, err);
    check_word("ram word 16", rd, mem_model[16]);
    // past the end of ram, would alias word 0
    apb_write(32'h0000_0400, ~mem_model[0], err);
    check_bit("pslverr ram range write", err, 1'b1);
    apb_read(32'h0000_0400, rd, err);
    check_bit("pslverr ram range read", err, 1'b1);
    apb_read(ram_byte_addr(8'd0), rd, err);
    check_word("ram word 0", rd, mem_model[0]);
    // above status register
    apb_write(PERIPH_BASE + 32'd20, 32'hffff_ffff, err);
    check_bit("pslverr periph range write", err, 1'b1);
    apb_read(PERIPH_BASE + 32'd20, rd, err);
    check_bit("pslverr periph range read", err, 1'b1);
    // bad lengths refuse the start
    rx_flits.delete();
    apb_write(PERIPH_BASE + REG_DMA_LEN, 32'd0, err);
    check_bit("pslverr", err, 1'b0);
    apb_write(PERIPH_BASE + REG_DMA_DST, 32'h0707, err);
    check_bit("pslverr length 0 start", err, 1'b1);
    apb_write(PERIPH_BASE + REG_DMA_LEN, 32'd65, err);
    check_bit("pslverr", err, 1'b0);
    apb_write(PERIPH_BASE + REG_DMA_DST, 32'h0808, err);
    check_bit("pslverr length 65 start", err, 1'b1);
    apb_read(PERIPH_BASE + REG_DMA_STATUS, rd, err);
    check_word("dma status", rd, 32'h0);
    apb_read(PERIPH_BASE + REG_DMA_DST, rd, err);
    check_word("dma dst", rd, 32'h0300);   // from the previous good start
    check_count("flits after refused start", rx_flits.size(), 0);
    // setup frozen while busy
    load_words(8'd0, 10);
    start_dma(8'd0, 7'd10, 16'h0604);
    expect_packet(8'd0, 7'd10, 16'h0604);
    apb_write(PERIPH_BASE + REG_DMA_SRC, 32'h55, err);
    check_bit("pslverr busy src", err, 1'b1);
    apb_write(PERIPH_BASE + REG_DMA_LEN, 32'd3, err);
    check_bit("pslverr busy len", err, 1'b1);
    apb_write(PERIPH_BASE + REG_DMA_DST, 32'h0909, err);
    check_bit("pslverr busy dst", err, 1'b1);
    wait_irq();
    check_packet();
    apb_read(PERIPH_BASE + REG_DMA_SRC, rd, err);
    check_word("dma src", rd, 32'd0);
    apb_read(PERIPH_BASE + REG_DMA_LEN, rd, err);
    check_word("dma len", rd, 32'd10);
    apb_read(PERIPH_BASE + REG_DMA_DST, rd, err);
    check_word("dma dst", rd, 32'h0604);
    clear_irq();
    report_test("error responses", errs);
  endtask

  task automatic test_back_to_back();
    int errs;
    errs = error_count;
    rx_flits.delete();
    exp_flits.delete();
    load_words(8'd100, 1);
    load_words(8'd120, 3);
    load_words(8'd140, 4);
    start_dma(8'd100, 7'd1, 16'h0001);
    expect_packet(8'd100, 7'd1, 16'h0001);
    wait_irq();
    clear_irq();
    start_dma(8'd120, 7'd3, 16'h0402);
    expect_packet(8'd120, 7'd3, 16'h0402);
    wait_irq();
    clear_irq();
    start_dma(8'd140, 7'd4, 16'h0a0b);
    expect_packet(8'd140, 7'd4, 16'h0a0b);
    wait_irq();
    clear_irq();
    check_packet();   // three packets, framed end to end
    report_test("back-to-back transfers", errs);
  endtask

  // ======================================================================
  // main
  // ======================================================================
  initial begin
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    @(posedge clock);
    while (!reset) @(posedge clock);
    @(posedge clock);
    test_reset();
    test_ram_readback();
    test_dma_packet();
    test_backpressure();
    test_errors();
    test_back_to_back();
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, check_total, error_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : tb_pe_tile

`default_nettype wire

//--- sources.f
rtl/pe_pkg.sv
rtl/pe_apb_decode.sv
rtl/pe_dual_port_ram.sv
rtl/pe_dma_fetch.sv
rtl/pe_flit_serializer.sv
rtl/pe_credit_tx.sv
rtl/pe_tile.sv
testbench/tb_clock_gen.sv
testbench/tb_pe_tile.sv

//--- Makefile
TOOL      = verilator
FLAGS     = --timing
TOP       = tb_pe_tile
FILELIST  = sources.f
BUILD_DIR = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf $(BUILD_DIR)
